//--- common/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

////////////////////////////////////////////////////////////
// address and block geometry
////////////////////////////////////////////////////////////

// byte address width
`define ADDR_BITS          16
// one block is a double word
`define BLOCK_BYTES        8
`define BLOCK_BITS         (`BLOCK_BYTES * 8)
// byte offset inside a block, log2 of BLOCK_BYTES
`define BLOCK_OFFSET_BITS  3
`define BLOCK_ADDR_BITS    (`ADDR_BITS - `BLOCK_OFFSET_BITS)

////////////////////////////////////////////////////////////
// cache and miss handling
////////////////////////////////////////////////////////////

// direct mapped, one block per line
`define ICACHE_LINES       32
`define ICACHE_LINE_BITS   5
`define CACHE_TAG_BITS     (`BLOCK_ADDR_BITS - `ICACHE_LINE_BITS)

// blocks looked up per cycle
`define PREFETCH_DISTANCE  2
`define MSHR_ENTRIES       4
// requests memory can hold at once
`define MEM_CREDITS        4
// entry number plus one, zero means no tag
`define MEM_TAG_BITS       3

`endif

//--- common/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////

    typedef logic [`ADDR_BITS-1:0]       addr_t;
    // address with the byte offset dropped
    typedef logic [`BLOCK_ADDR_BITS-1:0] block_addr_t;
    typedef logic [`BLOCK_BITS-1:0]      mem_block_t;
    // nonzero tag names the owning entry
    typedef logic [`MEM_TAG_BITS-1:0]    mem_tag_t;

    ////////////////////////////////////////////////////////////
    // cache side
    ////////////////////////////////////////////////////////////

    // one per cache line
    typedef struct packed {
        logic                       valid;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } cache_tag_t;

    // one per lookup port
    typedef struct packed {
        logic       valid;
        mem_block_t data;
    } fetch_line_t;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
        mem_tag_t    tag;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        mem_tag_t   tag;
        mem_block_t data;
    } mem_rsp_t;

    ////////////////////////////////////////////////////////////
    // miss entries and fill
    ////////////////////////////////////////////////////////////

    // allocator to one entry
    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
        mem_tag_t    tag;
    } alloc_t;

    // busy covers waiting and done
    typedef struct packed {
        logic        busy;
        logic        done;
        block_addr_t block_addr;
    } mshr_status_t;

    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
        mem_block_t  data;
    } fill_t;

endpackage

//--- icache/icache.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache (
    input  logic                                            clock,
    input  logic                                            reset,
    input  icache_pkg::addr_t                               fetch_addr,
    input  icache_pkg::fill_t                               fill,
    output icache_pkg::fetch_line_t [`PREFETCH_DISTANCE-1:0] lines
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // tags and valid bits, cleared by reset
    icache_pkg::cache_tag_t [`ICACHE_LINES-1:0] tag_mem;
    // block data
    icache_pkg::mem_block_t data_mem [`ICACHE_LINES];

    // block number of the fetch address
    icache_pkg::block_addr_t fetch_block;

    // fill write port fields
    logic [`ICACHE_LINE_BITS-1:0] fill_index;
    logic [`CACHE_TAG_BITS-1:0]   fill_tag;

    assign fetch_block = fetch_addr[`ADDR_BITS-1:`BLOCK_OFFSET_BITS];

    // low bits pick the line, high bits are the tag
    assign fill_index = fill.block_addr[`ICACHE_LINE_BITS-1:0];
    assign fill_tag   = fill.block_addr[`BLOCK_ADDR_BITS-1:`ICACHE_LINE_BITS];

    ////////////////////////////////////////////////////////////
    // lookup ports
    ////////////////////////////////////////////////////////////

    // combinational read, port i looks at fetch block plus i
    always_comb begin
        icache_pkg::block_addr_t      blk;
        logic [`ICACHE_LINE_BITS-1:0] idx;
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            // wraps inside the block address width
            blk = fetch_block + icache_pkg::block_addr_t'(i);
            idx = blk[`ICACHE_LINE_BITS-1:0];
            // hit needs stored valid and same tag
            lines[i].valid = tag_mem[idx].valid &&
                (tag_mem[idx].tag == blk[`BLOCK_ADDR_BITS-1:`ICACHE_LINE_BITS]);
            lines[i].data  = data_mem[idx];
        end
    end

    ////////////////////////////////////////////////////////////
    // fill write port
    ////////////////////////////////////////////////////////////

    // tag side
    always_ff @(posedge clock) begin
        if (reset) begin
            tag_mem <= '0;
        end else if (fill.valid) begin
            tag_mem[fill_index].valid <= 1'b1;
            tag_mem[fill_index].tag   <= fill_tag;
        end
    end

    // data side, written together with the tag
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            data_mem[fill_index] <= fill.data;
        end
    end

    // fill address must be known whenever the arbiter drives a fill
    fill_addr_known: assert property (
        @(posedge clock) disable iff (reset)
        fill.valid |-> !$isunknown(fill.block_addr)
    ) else $error("icache: fill with unknown block address");

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    // free running clock
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2.0) clock = ~clock;
    end

    // reset held for RESET_CYCLES rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- sim/icache_tb.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_tb;

    localparam int CLOCK_PERIOD  = 4;
    // inputs settle this long after the falling edge before sampling
    localparam int SETTLE        = 1;
    localparam int MAX_LATENCY   = 12;
    // upper bound on requests over all tests
    localparam int TEST_REQUESTS = 32;
    localparam int WATCHDOG_CYCLES = TEST_REQUESTS * MAX_LATENCY + 600;

    logic                                             clock;
    logic                                             reset;
    icache_pkg::addr_t                                fetch_addr;
    icache_pkg::fetch_line_t [`PREFETCH_DISTANCE-1:0] lines;
    icache_pkg::mem_req_t                             mem_req;
    icache_pkg::mem_rsp_t                             mem_rsp;
    int                                               max_latency;
    logic                                             hold;

    // bus bookkeeping from the monitor
    int                      req_count;
    int                      rsp_count;
    logic                    tag_pending [1 << `MEM_TAG_BITS];
    icache_pkg::block_addr_t pending_block [1 << `MEM_TAG_BITS];
    logic                    dup_found;

    clock_gen #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(16)) u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    mem_model u_mem_model (
        .clock       (clock),
        .reset       (reset),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .max_latency (max_latency),
        .hold        (hold)
    );

    icache_fetch_top DUT (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .lines      (lines),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0.1f ns: %s (got %h, expected %h)", $realtime, what, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // memory fills block B with B repeated, XOR a fixed constant
    function automatic icache_pkg::mem_block_t expected_block(input icache_pkg::block_addr_t blk);
        logic [15:0] word;
        word = 16'(blk);
        return {word, word, word, word} ^ 64'h5A3C_96F0_0FF0_C3A5;
    endfunction

    function automatic icache_pkg::addr_t block_to_addr(input icache_pkg::block_addr_t blk);
        return {blk, 3'b000};
    endfunction

    // new address on the falling edge, lines are read before the next rise
    task automatic drive_addr(input icache_pkg::addr_t addr);
        @(negedge clock);
        fetch_addr = addr;
        #SETTLE;
    endtask

    task automatic check_lines_data(input icache_pkg::addr_t addr);
        icache_pkg::block_addr_t blk;
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            blk = addr[`ADDR_BITS-1:3] + icache_pkg::block_addr_t'(i);
            check_value(64'(lines[i].valid), 64'd1, $sformatf("port %0d valid", i));
            check_value(lines[i].data, expected_block(blk), $sformatf("port %0d data", i));
        end
    endtask

    // holds addr until every port hits; watchdog bounds the wait
    task automatic wait_lines_valid(input icache_pkg::addr_t addr);
        logic all_valid;
        all_valid = 1'b0;
        while (!all_valid) begin
            drive_addr(addr);
            all_valid = 1'b1;
            for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
                all_valid = all_valid & lines[i].valid;
            end
        end
        check_lines_data(addr);
    endtask

    // nothing in flight, entries drained into the cache
    task automatic wait_quiet();
        while (req_count != rsp_count) begin
            @(negedge clock);
        end
        repeat (3) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // bus monitor: credits and duplicate requests
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            req_count = 0;
            rsp_count = 0;
            for (int t = 0; t < (1 << `MEM_TAG_BITS); t++) begin
                tag_pending[t] = 1'b0;
            end
        end else begin
            if (mem_rsp.valid) begin
                check_value(64'(tag_pending[mem_rsp.tag]), 64'd1, "response tag not outstanding");
                tag_pending[mem_rsp.tag] = 1'b0;
                rsp_count++;
            end
            if (mem_req.valid) begin
                check_value(64'(mem_req.tag != '0), 64'd1, "request with tag zero");
                check_value(64'(tag_pending[mem_req.tag]), 64'd0, "request reuses a live tag");
                dup_found = 1'b0;
                for (int t = 1; t < (1 << `MEM_TAG_BITS); t++) begin
                    if (tag_pending[t] && (pending_block[t] == mem_req.block_addr)) begin
                        dup_found = 1'b1;
                    end
                end
                check_value(64'(dup_found), 64'd0, "block requested twice while outstanding");
                tag_pending[mem_req.tag]   = 1'b1;
                pending_block[mem_req.tag] = mem_req.block_addr;
                req_count++;
            end
            check_value(64'(req_count - rsp_count <= `MEM_CREDITS), 64'd1,
                        "more requests outstanding than credits");
        end
    end

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    // empty cache misses everywhere
    task automatic reset_lines_invalid();
        icache_pkg::addr_t addrs [3];
        addrs = '{16'h0080, 16'h0098, 16'h00C4};
        max_latency = MAX_LATENCY;
        foreach (addrs[k]) begin
            drive_addr(addrs[k]);
            for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
                check_value(64'(lines[i].valid), 64'd0, $sformatf("port %0d valid after reset", i));
            end
        end
    endtask

    task automatic cold_miss_fill();
        max_latency = 5;
        wait_lines_valid(16'h0203);
        wait_quiet();
    endtask

    // offsets inside block 0x040 keep both ports on cached blocks
    task automatic hit_sweep();
        int reqs_before;
        reqs_before = req_count;
        for (int off = 0; off < `BLOCK_BYTES; off++) begin
            drive_addr(16'h0200 + icache_pkg::addr_t'(off));
            check_lines_data(16'h0200 + icache_pkg::addr_t'(off));
        end
        @(negedge clock);
        check_value(64'(req_count), 64'(reqs_before), "request issued on a hit");
    endtask

    // block 0x060 shares index with 0x040, tag differs
    task automatic conflict_refill();
        drive_addr(block_to_addr(13'h060));
        check_value(64'(lines[0].valid), 64'd0, "conflicting block reads as hit");
        wait_lines_valid(block_to_addr(13'h060));
        // the old block was evicted
        drive_addr(block_to_addr(13'h040));
        check_value(64'(lines[0].valid), 64'd0, "evicted block reads as hit");
        wait_lines_valid(block_to_addr(13'h040));
        wait_quiet();
    endtask

    task automatic credit_limit();
        int reqs_held;
        hold        = 1'b1;
        max_latency = 2;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 6; k++) begin
                drive_addr(block_to_addr(13'h200 + 13'(2 * k)));
            end
        end
        reqs_held = req_count;
        // all entries and credits in use, misses must wait
        repeat (12) drive_addr(block_to_addr(13'h20A));
        check_value(64'(req_count - rsp_count), 64'(`MEM_CREDITS), "outstanding count while held");
        check_value(64'(req_count), 64'(reqs_held), "request without a credit");
        hold = 1'b0;
        for (int k = 0; k < 6; k++) begin
            wait_lines_valid(block_to_addr(13'h200 + 13'(2 * k)));
        end
        wait_quiet();
    endtask

    // random latencies reorder responses
    task automatic shuffled_fill();
        max_latency = MAX_LATENCY;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 4; k++) begin
                drive_addr(block_to_addr(13'h300 + 13'(2 * k)));
            end
        end
        for (int k = 3; k >= 0; k--) begin
            wait_lines_valid(block_to_addr(13'h300 + 13'(2 * k)));
        end
        wait_quiet();
    endtask

    ////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        fetch_addr  = '0;
        max_latency = 4;
        hold        = 1'b0;
        @(negedge reset);
        reset_lines_invalid();
        cold_miss_fill();
        hit_sweep();
        conflict_refill();
        credit_limit();
        shuffled_fill();
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

//--- sim/mem_model.sv
`timescale 1ns/100ps

module mem_model (
    input  logic                 clock,
    input  logic                 reset,
    input  icache_pkg::mem_req_t mem_req,
    output icache_pkg::mem_rsp_t mem_rsp,
    // upper bound on latency in cycles, at least 1
    input  int                   max_latency,
    // withholds every response while high
    input  logic                 hold
);

    // outstanding requests, one slot per queue index
    icache_pkg::mem_tag_t    pend_tag [$];
    icache_pkg::block_addr_t pend_blk [$];
    int                      pend_ready [$];
    // indices of requests that may answer now
    int                      ready_idx [$];
    int                      cycle;
    int                      pick;
    int unsigned             lcg_state = 32'd76461;

    // linear congruential generator, upper bits are the better ones
    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // block contents: block number repeated, then scrambled
    function automatic icache_pkg::mem_block_t block_pattern(input icache_pkg::block_addr_t blk);
        logic [15:0] word;
        word = 16'(blk);
        return {word, word, word, word} ^ 64'h5A3C_96F0_0FF0_C3A5;
    endfunction

    ////////////////////////////////////////////////////////////
    // accept requests on the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            pend_tag.delete();
            pend_blk.delete();
            pend_ready.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (mem_req.valid) begin
                pend_tag.push_back(mem_req.tag);
                pend_blk.push_back(mem_req.block_addr);
                // random latency from 1 to max_latency
                pend_ready.push_back(cycle + 1 + int'(lcg_next() % max_latency));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // one response per cycle, driven on the falling edge
    ////////////////////////////////////////////////////////////

    initial mem_rsp = '0;

    always @(negedge clock) begin
        ready_idx.delete();
        for (int i = 0; i < pend_tag.size(); i++) begin
            if (!hold && (pend_ready[i] <= cycle)) begin
                ready_idx.push_back(i);
            end
        end
        if (ready_idx.size() > 0) begin
            // random pick among ready requests gives out of order answers
            pick          = ready_idx[lcg_next() % ready_idx.size()];
            mem_rsp.valid = 1'b1;
            mem_rsp.tag   = pend_tag[pick];
            mem_rsp.data  = block_pattern(pend_blk[pick]);
            pend_tag.delete(pick);
            pend_blk.delete(pick);
            pend_ready.delete(pick);
        end else begin
            mem_rsp = '0;
        end
    end

endmodule

//--- source/fill_arbiter.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module fill_arbiter (
    input  logic                                         clock,
    input  logic                                         reset,
    input  icache_pkg::mshr_status_t [`MSHR_ENTRIES-1:0] status,
    input  icache_pkg::mem_block_t [`MSHR_ENTRIES-1:0]   data,
    output logic [`MSHR_ENTRIES-1:0]                     grant,
    output icache_pkg::fill_t                            fill
);

    localparam int ENTRY_BITS   = $clog2(`MSHR_ENTRIES);
    // one full turn of the pointer
    localparam int DRAIN_CYCLES = `MSHR_ENTRIES;

    // search starts here
    logic [ENTRY_BITS-1:0] ptr;
    logic [ENTRY_BITS-1:0] pick;
    logic                  found;

    ////////////////////////////////////////////////////////////
    // round robin over done entries
    ////////////////////////////////////////////////////////////

    always_comb begin
        int idx;
        found = 1'b0;
        pick  = ptr;
        grant = '0;
        for (int k = 0; k < `MSHR_ENTRIES; k++) begin
            idx = int'(ptr) + k;
            if (idx >= `MSHR_ENTRIES) begin
                idx = idx - `MSHR_ENTRIES;
            end
            if (!found && status[idx].done) begin
                found = 1'b1;
                pick  = ENTRY_BITS'(idx);
            end
        end
        if (found) begin
            grant[pick] = 1'b1;
        end
    end

    // granted entry straight to the cache write port
    assign fill.valid      = found;
    assign fill.block_addr = status[pick].block_addr;
    assign fill.data       = data[pick];

    // next search begins after the winner
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            if (pick == ENTRY_BITS'(`MSHR_ENTRIES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= pick + ENTRY_BITS'(1);
            end
        end
    end

    // no done entry is starved by the pointer
    for (genvar g = 0; g < `MSHR_ENTRIES; g++) begin : gen_drain_check
        done_drained: assert property (
            @(posedge clock) disable iff (reset)
            status[g].done |-> ##[0:DRAIN_CYCLES-1] grant[g]
        ) else $error("fill_arbiter: done entry not drained within one turn");
    end

endmodule

//--- source/icache_fetch_top.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_fetch_top (
    input  logic                                             clock,
    input  logic                                             reset,
    input  icache_pkg::addr_t                                fetch_addr,
    output icache_pkg::fetch_line_t [`PREFETCH_DISTANCE-1:0] lines,
    output icache_pkg::mem_req_t                             mem_req,
    input  icache_pkg::mem_rsp_t                             mem_rsp
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    icache_pkg::fill_t                            fill;
    icache_pkg::alloc_t [`MSHR_ENTRIES-1:0]       alloc;
    icache_pkg::mshr_status_t [`MSHR_ENTRIES-1:0] status;
    icache_pkg::mem_block_t [`MSHR_ENTRIES-1:0]   entry_data;
    logic [`MSHR_ENTRIES-1:0]                     grant;

    // lookup array, written by the fill port
    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fill       (fill),
        .lines      (lines)
    );

    // misses in, one allocation and request out
    miss_allocator u_miss_allocator (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .lines      (lines),
        .status     (status),
        .mem_rsp    (mem_rsp),
        .alloc      (alloc),
        .mem_req    (mem_req)
    );

    // one entry per tag, tag is index plus one
    for (genvar g = 0; g < `MSHR_ENTRIES; g++) begin : gen_mshr
        mshr_entry u_mshr_entry (
            .clock   (clock),
            .reset   (reset),
            .alloc   (alloc[g]),
            .mem_rsp (mem_rsp),
            .grant   (grant[g]),
            .status  (status[g]),
            .data    (entry_data[g])
        );
    end

    // finished entries drain one per cycle
    fill_arbiter u_fill_arbiter (
        .clock  (clock),
        .reset  (reset),
        .status (status),
        .data   (entry_data),
        .grant  (grant),
        .fill   (fill)
    );

endmodule

//--- source/miss_allocator.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module miss_allocator (
    input  logic                                             clock,
    input  logic                                             reset,
    input  icache_pkg::addr_t                                fetch_addr,
    input  icache_pkg::fetch_line_t [`PREFETCH_DISTANCE-1:0] lines,
    input  icache_pkg::mshr_status_t [`MSHR_ENTRIES-1:0]     status,
    input  icache_pkg::mem_rsp_t                             mem_rsp,
    output icache_pkg::alloc_t [`MSHR_ENTRIES-1:0]           alloc,
    output icache_pkg::mem_req_t                             mem_req
);

    localparam int CREDIT_BITS = $clog2(`MEM_CREDITS + 1);
    localparam int ENTRY_BITS  = $clog2(`MSHR_ENTRIES);

    logic [CREDIT_BITS-1:0]  credits;
    // held low through reset and the cycle after
    logic                    run;
    icache_pkg::block_addr_t fetch_block;
    icache_pkg::block_addr_t miss_block;
    logic                    miss_found;
    logic [ENTRY_BITS-1:0]   free_idx;
    logic                    free_found;
    logic                    issue;
    icache_pkg::mem_tag_t    new_tag;

    assign fetch_block = fetch_addr[`ADDR_BITS-1:`BLOCK_OFFSET_BITS];

    ////////////////////////////////////////////////////////////
    // miss selection
    ////////////////////////////////////////////////////////////

    // lowest port that misses and is not already in flight
    always_comb begin
        icache_pkg::block_addr_t blk;
        logic                    pending;
        miss_found = 1'b0;
        miss_block = fetch_block;
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            blk     = fetch_block + icache_pkg::block_addr_t'(i);
            pending = 1'b0;
            // busy includes done entries still waiting to drain
            for (int e = 0; e < `MSHR_ENTRIES; e++) begin
                if (status[e].busy && (status[e].block_addr == blk)) begin
                    pending = 1'b1;
                end
            end
            if (!miss_found && !lines[i].valid && !pending) begin
                miss_found = 1'b1;
                miss_block = blk;
            end
        end
    end

    // lowest idle entry
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int e = 0; e < `MSHR_ENTRIES; e++) begin
            if (!free_found && !status[e].busy) begin
                free_found = 1'b1;
                free_idx   = ENTRY_BITS'(e);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // allocate and request, same cycle
    ////////////////////////////////////////////////////////////

    assign issue   = run && miss_found && free_found && (credits != '0);
    // entry index plus one, tag zero stays unused
    assign new_tag = icache_pkg::mem_tag_t'(free_idx) + icache_pkg::mem_tag_t'(1);

    assign mem_req.valid      = issue;
    assign mem_req.block_addr = miss_block;
    assign mem_req.tag        = new_tag;

    // one entry at most sees valid
    always_comb begin
        for (int e = 0; e < `MSHR_ENTRIES; e++) begin
            alloc[e].valid      = issue && (free_idx == ENTRY_BITS'(e));
            alloc[e].block_addr = miss_block;
            alloc[e].tag        = new_tag;
        end
    end

    // credits: spend on request, refund on response
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_BITS'(`MEM_CREDITS);
            run     <= 1'b0;
        end else begin
            credits <= credits - CREDIT_BITS'(issue) + CREDIT_BITS'(mem_rsp.valid);
            run     <= 1'b1;
        end
    end

    credit_in_range: assert property (
        @(posedge clock) disable iff (reset)
        credits <= CREDIT_BITS'(`MEM_CREDITS)
    ) else $error("miss_allocator: credit count above limit");

    // full credits means nothing outstanding, so no response may come
    credit_no_underflow: assert property (
        @(posedge clock) disable iff (reset)
        mem_rsp.valid |-> (credits < CREDIT_BITS'(`MEM_CREDITS))
    ) else $error("miss_allocator: response without an outstanding request");

endmodule

//--- source/mshr_entry.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module mshr_entry (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::alloc_t       alloc,
    input  icache_pkg::mem_rsp_t     mem_rsp,
    input  logic                     grant,
    output icache_pkg::mshr_status_t status,
    output icache_pkg::mem_block_t   data
);

    typedef enum logic [1:0] {
        state_idle,
        state_wait,
        state_done
    } state_t;

    state_t                  state;
    // zero while never allocated
    icache_pkg::mem_tag_t    tag_q;
    icache_pkg::block_addr_t block_q;
    icache_pkg::mem_block_t  data_q;
    logic                    rsp_hit;

    // response carries our tag
    assign rsp_hit = mem_rsp.valid && (mem_rsp.tag == tag_q);

    ////////////////////////////////////////////////////////////
    // idle -> wait -> done -> idle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
            tag_q <= '0;
        end else begin
            case (state)
                state_idle: begin
                    if (alloc.valid) begin
                        state <= state_wait;
                        tag_q <= alloc.tag;
                    end
                end
                state_wait: begin
                    if (rsp_hit) begin
                        state <= state_done;
                    end
                end
                state_done: begin
                    // drained into the cache this edge
                    if (grant) begin
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // block address and data
    always_ff @(posedge clock) begin
        if ((state == state_idle) && alloc.valid) begin
            block_q <= alloc.block_addr;
        end
        if ((state == state_wait) && rsp_hit) begin
            data_q <= mem_rsp.data;
        end
    end

    assign status.busy       = (state != state_idle);
    assign status.done       = (state == state_done);
    assign status.block_addr = block_q;
    assign data              = data_q;

    // memory answers each tag once, and only after the request
    rsp_only_when_waiting: assert property (
        @(posedge clock) disable iff (reset)
        rsp_hit |-> (state == state_wait)
    ) else $error("mshr_entry: response for an entry that is not waiting");

    // allocator only picks idle entries
    alloc_only_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        alloc.valid |-> (state == state_idle)
    ) else $error("mshr_entry: allocation of a busy entry");

endmodule

//--- src.f
+incdir+common
common/icache_pkg.sv
icache/icache.sv
source/miss_allocator.sv
source/mshr_entry.sv
source/fill_arbiter.sv
source/icache_fetch_top.sv
sim/clock_gen.sv
sim/mem_model.sv
sim/icache_tb.sv
